/* verilog/sprite_pkg.sv */
// --------------------------------------------------------------------------
// shared sizes, sprite kind codes and the texel colour rule for sprite drawing
// --------------------------------------------------------------------------
package sprite_pkg;

	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;
	localparam int X_W = 9;
	localparam int Y_W = 8;
	localparam int FB_ADDR_W = 17;
	localparam int SPRITE_SIZE = 16;
	localparam int COLOR_W = 12;
	localparam int FIFO_DEPTH = 8;
	// two pixels in the datapath pipeline plus one
	localparam int FIFO_SLACK = 3;
	localparam logic KIND_GOLD = 1'b0;
	localparam logic KIND_STONE = 1'b1;

	// same 8 bits seen as rom offset or as row/col
	typedef union packed {
		logic [7:0] offset;
		struct packed {
			logic [3:0] row;
			logic [3:0] col;
		} rc;
	} texel_index_u;

	function automatic logic [COLOR_W-1:0] texel_color(input logic kind,
			input logic [3:0] row, input logic [3:0] col);
		if (kind == KIND_GOLD)
			return {4'hf, row, col};
		// stone checkerboard with transparent even squares
		if (row[0] ^ col[0])
			return {4'h8, col, row};
		return '0;
	endfunction

endpackage

/* verilog/sprite_rom.sv */
// --------------------------------------------------------------------------
// texel ROM holding the gold and stone sprites, one cycle read latency
// --------------------------------------------------------------------------
module sprite_rom import sprite_pkg::*; (
	input  logic               clk,
	input  logic               kind,
	input  logic [7:0]         index,
	output logic [COLOR_W-1:0] texel
);

	logic [COLOR_W-1:0] mem [2*SPRITE_SIZE*SPRITE_SIZE];

	// contents come straight from the texel rule
	initial begin
		for (int k = 0; k < 2; k++) begin
			for (int i = 0; i < SPRITE_SIZE*SPRITE_SIZE; i++) begin
				mem[k*SPRITE_SIZE*SPRITE_SIZE + i] =
					texel_color(k[0], i[7:4], i[3:0]);
			end
		end
	end

	always_ff @(posedge clk) begin
		texel <= mem[{kind, index}];
	end

endmodule

/* verilog/sprite_draw_ctrl.sv */
// --------------------------------------------------------------------------
// draw controller: accepts requests, walks 256 texels, counts sprites per kind
// --------------------------------------------------------------------------
module sprite_draw_ctrl import sprite_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       draw_req,
	input  logic       draw_kind,
	input  logic       clear_counts,
	input  logic       almost_full,
	output logic       busy,
	output logic       load_origin,
	output logic       step,
	output logic       last,
	output logic [7:0] gold_count,
	output logic [7:0] stone_count
);

	logic [7:0] step_cnt;
	logic       kind_r;

	// requests while walking are simply dropped
	assign load_origin = draw_req & ~busy;

	// hold off while the queue is nearly full
	assign step = busy & ~almost_full;
	assign last = step & (step_cnt == 8'(SPRITE_SIZE*SPRITE_SIZE - 1));

	// busy doubles as the state bit (low idle, high walk)
	always_ff @(posedge clk) begin
		if (!resetn)
			busy <= 1'b0;
		else if (load_origin)
			busy <= 1'b1;
		else if (last)
			busy <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			step_cnt <= '0;
		else if (load_origin)
			step_cnt <= '0;
		else if (step)
			step_cnt <= step_cnt + 8'd1;
	end

	always_ff @(posedge clk) begin
		if (load_origin)
			kind_r <= draw_kind;
	end

	// clear wins over a bump in the same cycle
	always_ff @(posedge clk) begin
		if (!resetn || clear_counts) begin
			gold_count <= '0;
			stone_count <= '0;
		end else if (last) begin
			if (kind_r == KIND_GOLD)
				gold_count <= gold_count + 8'd1;
			else
				stone_count <= stone_count + 8'd1;
		end
	end

endmodule

/* verilog/sprite_datapath.sv */
// --------------------------------------------------------------------------
// sprite datapath: texel counter, ROM lookup and screen coordinate of each pixel
// --------------------------------------------------------------------------
module sprite_datapath import sprite_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic [X_W-1:0]     draw_x,
	input  logic [Y_W-1:0]     draw_y,
	input  logic               draw_kind,
	input  logic               load_origin,
	input  logic               step,
	output logic               push,
	output logic [X_W-1:0]     pix_x,
	output logic [Y_W-1:0]     pix_y,
	output logic [COLOR_W-1:0] pix_color,
	output logic               pending
);

	logic [X_W-1:0]     org_x;
	logic [Y_W-1:0]     org_y;
	logic               kind_r;
	texel_index_u       idx;
	logic [COLOR_W-1:0] texel;
	logic               valid1;
	logic [X_W-1:0]     sum_x1;
	logic [Y_W-1:0]     sum_y1;

	always_ff @(posedge clk) begin
		if (load_origin) begin
			org_x <= draw_x;
			org_y <= draw_y;
			kind_r <= draw_kind;
		end
	end

	always_ff @(posedge clk) begin
		if (load_origin)
			idx.offset <= '0;
		else if (step)
			idx.offset <= idx.offset + 8'd1;
	end

	sprite_rom u_rom (
		.clk   (clk),
		.kind  (kind_r),
		.index (idx.offset),
		.texel (texel)
	);

	// stage 1 runs alongside the rom read
	// origin is added here so a new request cannot disturb pixels in flight
	always_ff @(posedge clk) begin
		if (step) begin
			sum_x1 <= org_x + X_W'(idx.rc.col);
			sum_y1 <= org_y + Y_W'(idx.rc.row);
		end
	end

	always_ff @(posedge clk) begin
		pix_x <= sum_x1;
		pix_y <= sum_y1;
		pix_color <= texel;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			valid1 <= 1'b0;
			push <= 1'b0;
		end else begin
			valid1 <= step;
			push <= valid1;
		end
	end

	assign pending = valid1 | push;

endmodule

/* verilog/pixel_fifo.sv */
// --------------------------------------------------------------------------
// pixel queue, eight entries, first-word fall-through with almost-full level
// --------------------------------------------------------------------------
module pixel_fifo import sprite_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               push,
	input  logic [X_W-1:0]     push_x,
	input  logic [Y_W-1:0]     push_y,
	input  logic [COLOR_W-1:0] push_color,
	input  logic               pop,
	output logic [X_W-1:0]     pop_x,
	output logic [Y_W-1:0]     pop_y,
	output logic [COLOR_W-1:0] pop_color,
	output logic               empty,
	output logic               almost_full
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int WORD_W = X_W + Y_W + COLOR_W;

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	// one extra bit so full and empty differ
	logic [PTR_W:0]    wr_ptr;
	logic [PTR_W:0]    rd_ptr;
	logic [PTR_W:0]    fill;

	assign fill = wr_ptr - rd_ptr;
	assign empty = (fill == '0);
	assign almost_full = (fill >= (PTR_W+1)'(FIFO_DEPTH - FIFO_SLACK));

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[PTR_W-1:0]] <= {push_x, push_y, push_color};
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign {pop_x, pop_y, pop_color} = mem[rd_ptr[PTR_W-1:0]];

endmodule

/* verilog/frame_writer.sv */
// --------------------------------------------------------------------------
// frame writer: drops transparent and off-screen pixels, holds the frame buffer
// --------------------------------------------------------------------------
module frame_writer import sprite_pkg::*; (
	input  logic               clk,
	input  logic [X_W-1:0]     pix_x,
	input  logic [Y_W-1:0]     pix_y,
	input  logic [COLOR_W-1:0] pix_color,
	input  logic               empty,
	input  logic [X_W-1:0]     rd_x,
	input  logic [Y_W-1:0]     rd_y,
	output logic               pop,
	output logic [COLOR_W-1:0] rd_color
);

	logic [COLOR_W-1:0]   fb [SCREEN_W*SCREEN_H];
	logic [FB_ADDR_W-1:0] wr_addr;
	logic [FB_ADDR_W-1:0] rd_addr;
	logic                 on_screen;
	logic                 wr_en;

	// drain one pixel every cycle
	assign pop = ~empty;

	assign on_screen = (pix_x < X_W'(SCREEN_W)) && (pix_y < Y_W'(SCREEN_H));
	assign wr_en = pop && on_screen && (pix_color != '0);

	// row major, y * 320 + x
	assign wr_addr = FB_ADDR_W'(pix_y) * FB_ADDR_W'(SCREEN_W) + FB_ADDR_W'(pix_x);
	assign rd_addr = FB_ADDR_W'(rd_y) * FB_ADDR_W'(SCREEN_W) + FB_ADDR_W'(rd_x);

	always_ff @(posedge clk) begin
		if (wr_en)
			fb[wr_addr] <= pix_color;
	end

	// display side read port
	always_ff @(posedge clk) begin
		rd_color <= fb[rd_addr];
	end

endmodule

/* verilog/sprite_draw_top.sv */
// --------------------------------------------------------------------------
// sprite drawing top: controller, datapath, pixel queue and frame writer
// --------------------------------------------------------------------------
module sprite_draw_top import sprite_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               draw_req,
	input  logic [X_W-1:0]     draw_x,
	input  logic [Y_W-1:0]     draw_y,
	input  logic               draw_kind,
	input  logic               clear_counts,
	input  logic [X_W-1:0]     rd_x,
	input  logic [Y_W-1:0]     rd_y,
	output logic               busy,
	output logic [7:0]         gold_count,
	output logic [7:0]         stone_count,
	output logic               idle,
	output logic [COLOR_W-1:0] rd_color
);

	logic               load_origin;
	logic               step;
	logic               push;
	logic               pending;
	logic               almost_full;
	logic               empty;
	logic               pop;
	logic [X_W-1:0]     pix_x;
	logic [Y_W-1:0]     pix_y;
	logic [COLOR_W-1:0] pix_color;
	logic [X_W-1:0]     q_x;
	logic [Y_W-1:0]     q_y;
	logic [COLOR_W-1:0] q_color;

	assign idle = ~busy & ~pending & empty;

	// last only feeds the per-kind counts inside the controller
	sprite_draw_ctrl u_ctrl (
		.clk          (clk),
		.resetn       (resetn),
		.draw_req     (draw_req),
		.draw_kind    (draw_kind),
		.clear_counts (clear_counts),
		.almost_full  (almost_full),
		.busy         (busy),
		.load_origin  (load_origin),
		.step         (step),
		.last         (),
		.gold_count   (gold_count),
		.stone_count  (stone_count)
	);

	sprite_datapath u_datapath (
		.clk         (clk),
		.resetn      (resetn),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.draw_kind   (draw_kind),
		.load_origin (load_origin),
		.step        (step),
		.push        (push),
		.pix_x       (pix_x),
		.pix_y       (pix_y),
		.pix_color   (pix_color),
		.pending     (pending)
	);

	pixel_fifo u_fifo (
		.clk         (clk),
		.resetn      (resetn),
		.push        (push),
		.push_x      (pix_x),
		.push_y      (pix_y),
		.push_color  (pix_color),
		.pop         (pop),
		.pop_x       (q_x),
		.pop_y       (q_y),
		.pop_color   (q_color),
		.empty       (empty),
		.almost_full (almost_full)
	);

	frame_writer u_writer (
		.clk       (clk),
		.pix_x     (q_x),
		.pix_y     (q_y),
		.pix_color (q_color),
		.empty     (empty),
		.rd_x      (rd_x),
		.rd_y      (rd_y),
		.pop       (pop),
		.rd_color  (rd_color)
	);

endmodule

/* testbench/tb_checker.sv */
// --------------------------------------------------------------------------
// checker: shadow frame of accepted sprites, read-back and count compares
// --------------------------------------------------------------------------
module tb_checker import sprite_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               draw_req,
	input  logic [X_W-1:0]     draw_x,
	input  logic [Y_W-1:0]     draw_y,
	input  logic               draw_kind,
	input  logic               clear_counts,
	input  logic [X_W-1:0]     rd_x,
	input  logic [Y_W-1:0]     rd_y,
	input  logic               rd_check,
	input  logic               busy,
	input  logic               idle,
	input  logic [7:0]         gold_count,
	input  logic [7:0]         stone_count,
	input  logic [COLOR_W-1:0] rd_color,
	output int                 frame_errors,
	output int                 count_errors,
	output int                 reset_errors,
	output int                 reads_checked
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [COLOR_W-1:0] shadow [SCREEN_W*SCREEN_H];
	// pixels never drawn hold whatever the frame buffer powered up with
	bit                 known [SCREEN_W*SCREEN_H];
	bit                 out_of_reset;
	bit                 chk_pending;
	bit                 counts_seen;
	int                 chk_x;
	int                 chk_y;
	logic [7:0]         exp_gold;
	logic [7:0]         exp_stone;

	// gold is row then col, stone only where row plus col is odd
	function automatic logic [COLOR_W-1:0] ref_texel(input logic kind, input int row,
			input int col);
		if (kind == KIND_GOLD)
			return {4'hf, 4'(row), 4'(col)};
		if ((row + col) % 2 == 1)
			return {4'h8, 4'(col), 4'(row)};
		return '0;
	endfunction

	task automatic paint_sprite(input int ox, input int oy, input logic kind);
		int px;
		int py;
		logic [COLOR_W-1:0] c;
		for (int r = 0; r < SPRITE_SIZE; r++) begin
			for (int k = 0; k < SPRITE_SIZE; k++) begin
				px = ox + k;
				py = oy + r;
				c = ref_texel(kind, r, k);
				if (px < SCREEN_W && py < SCREEN_H && c != '0) begin
					shadow[py*SCREEN_W + px] = c;
					known[py*SCREEN_W + px] = 1'b1;
				end
			end
		end
	endtask

	always @(posedge clk) begin
		if (!resetn) begin
			out_of_reset = 1'b0;
			chk_pending = 1'b0;
			counts_seen = 1'b0;
			exp_gold = '0;
			exp_stone = '0;
			frame_errors = 0;
			count_errors = 0;
			reset_errors = 0;
			reads_checked = 0;
		end else begin
			if (!out_of_reset) begin
				out_of_reset = 1'b1;
				if (busy !== 1'b0 || idle !== 1'b1 || gold_count !== 8'd0 ||
						stone_count !== 8'd0) begin
					$display("ERROR busy/idle/gold_count/stone_count after reset: %h/%h/%h/%h %s",
						busy, idle, gold_count, stone_count, "expected 0/1/00/00");
					reset_errors++;
				end
			end
			// read data trails the address by one cycle
			if (chk_pending && known[chk_y*SCREEN_W + chk_x]) begin
				reads_checked++;
				if (rd_color !== shadow[chk_y*SCREEN_W + chk_x]) begin
					$display("ERROR rd_color at x %0d y %0d: got %h expected %h",
						chk_x, chk_y, rd_color, shadow[chk_y*SCREEN_W + chk_x]);
					frame_errors++;
				end
			end
			chk_pending = rd_check && rd_x < X_W'(SCREEN_W) && rd_y < Y_W'(SCREEN_H);
			chk_x = int'(rd_x);
			chk_y = int'(rd_y);
			// once per idle stretch, and again after a clear
			if (!idle || clear_counts) begin
				counts_seen = 1'b0;
			end else if (!counts_seen) begin
				counts_seen = 1'b1;
				if (gold_count !== exp_gold || stone_count !== exp_stone) begin
					$display("ERROR gold_count/stone_count: got %h/%h expected %h/%h",
						gold_count, stone_count, exp_gold, exp_stone);
					count_errors++;
				end
			end
			if (clear_counts) begin
				exp_gold = '0;
				exp_stone = '0;
			end
			if (draw_req && !busy) begin
				paint_sprite(int'(draw_x), int'(draw_y), draw_kind);
				if (draw_kind == KIND_GOLD)
					exp_gold++;
				else
					exp_stone++;
			end
		end
	end

endmodule

/* testbench/tb_top.sv */
// --------------------------------------------------------------------------
// sprite drawing testbench: directed and random draws, frame read-back
// --------------------------------------------------------------------------
module tb_top import sprite_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_SPRITES = 40;
	localparam int SPRITE_CYCLES = 256 + 64;
	localparam int READ_CYCLES = SCREEN_W*SCREEN_H + 8*400;
	localparam int WATCHDOG_CYCLES = 2 * (16 + MAX_SPRITES*SPRITE_CYCLES + READ_CYCLES);
	localparam int RANDOM_SPRITES = 28;

	logic               clk;
	logic               resetn;
	logic               draw_req;
	logic [X_W-1:0]     draw_x;
	logic [Y_W-1:0]     draw_y;
	logic               draw_kind;
	logic               clear_counts;
	logic [X_W-1:0]     rd_x;
	logic [Y_W-1:0]     rd_y;
	logic               rd_check;
	logic               busy;
	logic               idle;
	logic [7:0]         gold_count;
	logic [7:0]         stone_count;
	logic [COLOR_W-1:0] rd_color;
	int                 frame_errors;
	int                 count_errors;
	int                 reset_errors;
	int                 reads_checked;
	int                 tb_errors;
	int                 gold_issued;
	int                 stone_issued;
	logic [31:0]        lfsr_state;

	sprite_draw_top dut (.*);

	tb_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic drive_draw(input int x, input int y, input logic kind);
		@(posedge clk);
		draw_req <= 1'b1;
		draw_x <= X_W'(x);
		draw_y <= Y_W'(y);
		draw_kind <= kind;
		@(posedge clk);
		draw_req <= 1'b0;
	endtask

	task automatic request_sprite(input int x, input int y, input logic kind);
		if (kind == KIND_GOLD)
			gold_issued++;
		else
			stone_issued++;
		drive_draw(x, y, kind);
	endtask

	task automatic wait_for_idle(input string what);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!idle && n < 4*SPRITE_CYCLES);
		if (!idle) begin
			$display("drawing did not finish after the %s", what);
			tb_errors++;
		end
	endtask

	task automatic read_region(input int x0, input int y0, input int w, input int h);
		for (int y = y0; y < y0 + h; y++) begin
			for (int x = x0; x < x0 + w; x++) begin
				if (x < SCREEN_W && y < SCREEN_H) begin
					@(posedge clk);
					rd_x <= X_W'(x);
					rd_y <= Y_W'(y);
					rd_check <= 1'b1;
				end
			end
		end
		@(posedge clk);
		rd_check <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic check_counts(input int gold, input int stone);
		if (gold_count !== 8'(gold) || stone_count !== 8'(stone)) begin
			$display("ERROR gold_count/stone_count: got %h/%h expected %h/%h",
				gold_count, stone_count, 8'(gold), 8'(stone));
			tb_errors++;
		end
	endtask

	initial begin
		int x;
		int y;
		int kind;
		int gap;
		int cluster;
		lfsr_state = 32'ha830_de67;
		tb_errors = 0;
		gold_issued = 0;
		stone_issued = 0;
		resetn <= 1'b0;
		draw_req <= 1'b0;
		draw_x <= '0;
		draw_y <= '0;
		draw_kind <= 1'b0;
		clear_counts <= 1'b0;
		rd_x <= '0;
		rd_y <= '0;
		rd_check <= 1'b0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;
		repeat (2) @(posedge clk);

		// gold fully on screen, then stone on top of it
		request_sprite(20, 30, KIND_GOLD);
		wait_for_idle("gold sprite");
		read_region(18, 28, 20, 20);
		request_sprite(20, 30, KIND_STONE);
		wait_for_idle("stone sprite");
		read_region(18, 28, 20, 20);

		// right edge spill would alias onto the left sprite one row down
		request_sprite(0, 96, KIND_GOLD);
		wait_for_idle("left edge sprite");
		request_sprite(312, 96, KIND_GOLD);
		wait_for_idle("right edge sprite");
		request_sprite(100, 232, KIND_STONE);
		wait_for_idle("bottom edge sprite");
		request_sprite(310, 230, KIND_GOLD);
		wait_for_idle("corner sprite");
		read_region(0, 94, 20, 20);
		read_region(300, 94, 20, 20);
		read_region(96, 228, 24, 12);
		read_region(300, 226, 20, 14);

		// second request arrives mid walk and is dropped
		request_sprite(40, 40, KIND_GOLD);
		repeat (5) @(posedge clk);
		drive_draw(100, 232, KIND_GOLD);
		wait_for_idle("sprite with a dropped request");
		read_region(96, 228, 24, 12);
		check_counts(gold_issued, stone_issued);
		@(posedge clk);
		clear_counts <= 1'b1;
		@(posedge clk);
		clear_counts <= 1'b0;
		@(posedge clk);
		check_counts(0, 0);
		gold_issued = 0;
		stone_issued = 0;

		// half of them crowd the bottom right corner so they overlap and clip
		for (int i = 0; i < RANDOM_SPRITES; i++) begin
			take_bits(1, cluster);
			if (cluster != 0) begin
				take_bits(5, x);
				take_bits(5, y);
				x = x + 280;
				y = y + 200;
			end else begin
				take_bits(9, x);
				take_bits(8, y);
				x = x % SCREEN_W;
				y = y % SCREEN_H;
			end
			take_bits(1, kind);
			take_bits(3, gap);
			do
				@(posedge clk);
			while (busy);
			repeat (gap) @(posedge clk);
			request_sprite(x, y, kind[0]);
		end
		wait_for_idle("random sprites");
		check_counts(gold_issued, stone_issued);
		read_region(0, 0, SCREEN_W, SCREEN_H);

		if (reads_checked == 0) begin
			$display("no frame buffer read was ever compared");
			tb_errors++;
		end
		$display("frame errors %0d, count errors %0d, reset errors %0d, other errors %0d, %s %0d",
			frame_errors, count_errors, reset_errors, tb_errors, "pixels compared",
			reads_checked);
		if (frame_errors + count_errors + reset_errors + tb_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

/* files.f */
verilog/sprite_pkg.sv
verilog/sprite_rom.sv
verilog/sprite_draw_ctrl.sv
verilog/sprite_datapath.sv
verilog/pixel_fifo.sv
verilog/frame_writer.sv
verilog/sprite_draw_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary -Wno-fatal --top-module tb_top -f files.f -o tb_top_sim &&
sim_out=$(./obj_dir/tb_top_sim) &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -q "Verification passed" ||
{ echo "simulation did not pass"; exit 1; }
